/* Makefile */
# Verilator flow for the execution back end

VERILATOR ?= verilator
TOP       ?= exec_unit_tb
FILELIST  ?= exec_unit.f
OBJ_DIR   ?= obj_dir
LINT_FLAGS ?= --lint-only -Wall
SIM_FLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Verification passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* common/exec_consts.svh */
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// register and data width
`define GPR_SIZE 64

// reorder buffer tag width
`define ROB_IDX_SIZE 5

// data memory depth in doublewords
`define DMEM_WORDS 512

`endif

/* common/exec_pkg.sv */
`default_nettype none

package exec_pkg;

  // micro-op codes shared by both stations
  typedef enum logic [3:0] {
    PLUS,
    MINUS,
    ORN,
    OR,
    EOR,
    AND,
    CSNEG,
    CSINC,
    CSINV,
    CSEL,
    MOV,
    LDUR,
    STUR
  } fu_op_t;

  // ARM condition code encoding
  typedef enum logic [3:0] {
    EQ,
    NE,
    CS,
    CC,
    MI,
    PL,
    VS,
    VC,
    HI,
    LS,
    GE,
    LT,
    GT,
    LE,
    AL,
    NV
  } cond_t;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } nzcv_t;

endpackage

`default_nettype wire

/* design/alu.sv */
`default_nettype none

`include "exec_consts.svh"

module alu (
  input  wire exec_pkg::fu_op_t  op,
  input  wire [`GPR_SIZE-1:0]    val_a,
  input  wire [`GPR_SIZE-1:0]    val_b,
  input  wire                    set_nzcv,
  input  wire exec_pkg::nzcv_t   nzcv_in,
  input  wire exec_pkg::cond_t   cond,
  output logic [`GPR_SIZE-1:0]   value,
  output exec_pkg::nzcv_t        nzcv_out
);

  // one extra bit keeps the carry out
  logic [`GPR_SIZE:0] result;
  logic               cond_ok;
  logic               sign_a;
  logic               sign_b;
  logic               sign_r;

  assign sign_a = val_a[`GPR_SIZE-1];
  assign sign_b = val_b[`GPR_SIZE-1];
  assign sign_r = result[`GPR_SIZE-1];
  assign value  = result[`GPR_SIZE-1:0];

  // condition check against the incoming flags
  always_comb begin
    case (cond)
      exec_pkg::EQ: cond_ok = nzcv_in.z;
      exec_pkg::NE: cond_ok = !nzcv_in.z;
      exec_pkg::CS: cond_ok = nzcv_in.c;
      exec_pkg::CC: cond_ok = !nzcv_in.c;
      exec_pkg::MI: cond_ok = nzcv_in.n;
      exec_pkg::PL: cond_ok = !nzcv_in.n;
      exec_pkg::VS: cond_ok = nzcv_in.v;
      exec_pkg::VC: cond_ok = !nzcv_in.v;
      exec_pkg::HI: cond_ok = nzcv_in.c && !nzcv_in.z;
      exec_pkg::LS: cond_ok = !(nzcv_in.c && !nzcv_in.z);
      exec_pkg::GE: cond_ok = nzcv_in.n == nzcv_in.v;
      exec_pkg::LT: cond_ok = nzcv_in.n != nzcv_in.v;
      exec_pkg::GT: cond_ok = !nzcv_in.z && (nzcv_in.n == nzcv_in.v);
      exec_pkg::LE: cond_ok = nzcv_in.z || (nzcv_in.n != nzcv_in.v);
      default:      cond_ok = 1'b1;
    endcase
  end

  always_comb begin
    case (op)
      exec_pkg::PLUS:  result = {1'b0, val_a} + {1'b0, val_b};
      // subtract as a + ~b + 1, so bit 64 means no borrow
      exec_pkg::MINUS: result = {1'b0, val_a} + {1'b0, ~val_b} + 1'b1;
      exec_pkg::ORN:   result = {1'b0, val_a | ~val_b};
      exec_pkg::OR:    result = {1'b0, val_a | val_b};
      exec_pkg::EOR:   result = {1'b0, val_a ^ val_b};
      exec_pkg::AND:   result = {1'b0, val_a & val_b};
      exec_pkg::CSNEG: result = cond_ok ? {1'b0, val_a} : {1'b0, ~val_b} + 1'b1;
      exec_pkg::CSINC: result = cond_ok ? {1'b0, val_a} : {1'b0, val_b} + 1'b1;
      exec_pkg::CSINV: result = cond_ok ? {1'b0, val_a} : {1'b0, ~val_b};
      exec_pkg::CSEL:  result = cond_ok ? {1'b0, val_a} : {1'b0, val_b};
      // shift amount is always zero here
      exec_pkg::MOV:   result = {1'b0, val_a | val_b};
      default:         result = '0;
    endcase
  end

  always_comb begin
    if (set_nzcv) begin
      nzcv_out.n = sign_r;
      nzcv_out.z = (value == '0);
      nzcv_out.c = result[`GPR_SIZE];
      case (op)
        exec_pkg::PLUS:  nzcv_out.v = (sign_a == sign_b) && (sign_r != sign_a);
        exec_pkg::MINUS: nzcv_out.v = (sign_a != sign_b) && (sign_r != sign_a);
        default:         nzcv_out.v = 1'b0;
      endcase
    end else begin
      nzcv_out = nzcv_in;
    end
  end

endmodule

`default_nettype wire

/* design/exec_unit.sv */
`default_nettype none

`include "exec_consts.svh"

module exec_unit (
  input  wire                         clk,
  input  wire                         arst_n,
  // arithmetic station
  input  wire                         alu_req,
  output logic                        alu_ack,
  input  wire exec_pkg::fu_op_t       alu_op,
  input  wire [`GPR_SIZE-1:0]         alu_val_a,
  input  wire [`GPR_SIZE-1:0]         alu_val_b,
  input  wire [`ROB_IDX_SIZE-1:0]     alu_rob_idx,
  input  wire                         alu_set_nzcv,
  input  wire exec_pkg::nzcv_t        alu_nzcv,
  input  wire exec_pkg::cond_t        alu_cond,
  // load/store station
  input  wire                         ls_req,
  output logic                        ls_ack,
  input  wire exec_pkg::fu_op_t       ls_op,
  input  wire [`GPR_SIZE-1:0]         ls_val_a,
  input  wire [`GPR_SIZE-1:0]         ls_val_b,
  input  wire [`ROB_IDX_SIZE-1:0]     ls_rob_idx,
  // reorder buffer
  output logic                        rob_req,
  input  wire                         rob_ack,
  output logic [`ROB_IDX_SIZE-1:0]    rob_idx,
  output logic [`GPR_SIZE-1:0]        rob_value,
  output logic                        rob_set_nzcv,
  output exec_pkg::nzcv_t             rob_nzcv
);

  logic                      iss_valid;
  logic                      iss_is_ls;
  exec_pkg::fu_op_t          iss_op;
  logic [`GPR_SIZE-1:0]      iss_val_a;
  logic [`GPR_SIZE-1:0]      iss_val_b;
  logic [`ROB_IDX_SIZE-1:0]  iss_rob_idx;
  logic                      iss_set_nzcv;
  exec_pkg::nzcv_t           iss_nzcv;
  exec_pkg::cond_t           iss_cond;

  logic                      ex_valid;
  logic [`ROB_IDX_SIZE-1:0]  ex_rob_idx;
  logic [`GPR_SIZE-1:0]      ex_value;
  logic                      ex_set_nzcv;
  exec_pkg::nzcv_t           ex_nzcv;

  // hold signals run upstream
  logic                      ex_hold;
  logic                      wb_hold;

  issue_stage u_issue (.*);

  execute_stage u_execute (.*);

  writeback_stage u_writeback (.*);

endmodule

`default_nettype wire

/* design/execute_stage.sv */
`default_nettype none

`include "exec_consts.svh"

module execute_stage (
  input  wire                         clk,
  input  wire                         arst_n,
  input  wire                         iss_valid,
  input  wire                         iss_is_ls,
  input  wire exec_pkg::fu_op_t       iss_op,
  input  wire [`GPR_SIZE-1:0]         iss_val_a,
  input  wire [`GPR_SIZE-1:0]         iss_val_b,
  input  wire [`ROB_IDX_SIZE-1:0]     iss_rob_idx,
  input  wire                         iss_set_nzcv,
  input  wire exec_pkg::nzcv_t        iss_nzcv,
  input  wire exec_pkg::cond_t        iss_cond,
  input  wire                         wb_hold,
  output logic                        ex_hold,
  output logic                        ex_valid,
  output logic [`ROB_IDX_SIZE-1:0]    ex_rob_idx,
  output logic [`GPR_SIZE-1:0]        ex_value,
  output logic                        ex_set_nzcv,
  output exec_pkg::nzcv_t             ex_nzcv
);

  logic [`GPR_SIZE-1:0]           alu_value;
  exec_pkg::nzcv_t                alu_nzcv;
  logic [$clog2(`DMEM_WORDS)-1:0] mem_idx;
  logic                           mem_wr;
  logic                           mem_en;
  logic [`GPR_SIZE-1:0]           mem_rdata;
  logic [`GPR_SIZE-1:0]           alu_value_q;
  logic                           ex_is_ls;

  assign ex_hold = ex_valid && wb_hold;

  // memory is accessed on the same edge the stage captures
  assign mem_en = iss_valid && iss_is_ls && !ex_hold;

  alu u_alu (
    .op       (iss_op),
    .val_a    (iss_val_a),
    .val_b    (iss_val_b),
    .set_nzcv (iss_set_nzcv),
    .nzcv_in  (iss_nzcv),
    .cond     (iss_cond),
    .value    (alu_value),
    .nzcv_out (alu_nzcv)
  );

  lsu_addr u_lsu_addr (
    .op       (iss_op),
    .val_a    (iss_val_a),
    .val_b    (iss_val_b),
    .word_idx (mem_idx),
    .wr_en    (mem_wr)
  );

  data_mem u_data_mem (
    .clk      (clk),
    .en       (mem_en),
    .wr_en    (mem_wr),
    .word_idx (mem_idx),
    .wdata    (iss_val_b),
    .rdata    (mem_rdata)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_valid <= 1'b0;
    end else if (!ex_hold) begin
      ex_valid <= iss_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (iss_valid && !ex_hold) begin
      ex_rob_idx  <= iss_rob_idx;
      ex_is_ls    <= iss_is_ls;
      alu_value_q <= alu_value;
      // memory results never touch the flags
      ex_set_nzcv <= iss_is_ls ? 1'b0 : iss_set_nzcv;
      ex_nzcv     <= iss_is_ls ? '0 : alu_nzcv;
    end
  end

  assign ex_value = ex_is_ls ? mem_rdata : alu_value_q;

endmodule

`default_nettype wire

/* design/issue_stage.sv */
`default_nettype none

`include "exec_consts.svh"

module issue_stage (
  input  wire                         clk,
  input  wire                         arst_n,
  input  wire                         alu_req,
  output logic                        alu_ack,
  input  wire exec_pkg::fu_op_t       alu_op,
  input  wire [`GPR_SIZE-1:0]         alu_val_a,
  input  wire [`GPR_SIZE-1:0]         alu_val_b,
  input  wire [`ROB_IDX_SIZE-1:0]     alu_rob_idx,
  input  wire                         alu_set_nzcv,
  input  wire exec_pkg::nzcv_t        alu_nzcv,
  input  wire exec_pkg::cond_t        alu_cond,
  input  wire                         ls_req,
  output logic                        ls_ack,
  input  wire exec_pkg::fu_op_t       ls_op,
  input  wire [`GPR_SIZE-1:0]         ls_val_a,
  input  wire [`GPR_SIZE-1:0]         ls_val_b,
  input  wire [`ROB_IDX_SIZE-1:0]     ls_rob_idx,
  input  wire                         ex_hold,
  output logic                        iss_valid,
  output logic                        iss_is_ls,
  output exec_pkg::fu_op_t            iss_op,
  output logic [`GPR_SIZE-1:0]        iss_val_a,
  output logic [`GPR_SIZE-1:0]        iss_val_b,
  output logic [`ROB_IDX_SIZE-1:0]    iss_rob_idx,
  output logic                        iss_set_nzcv,
  output exec_pkg::nzcv_t             iss_nzcv,
  output exec_pkg::cond_t             iss_cond
);

  logic can_take;
  logic ls_take;
  logic alu_take;

  // slot is free when empty or moving on into execute
  assign can_take = !iss_valid || !ex_hold;
  // load/store port has fixed priority
  assign ls_take  = ls_req && !ls_ack && can_take;
  assign alu_take = alu_req && !alu_ack && can_take && !ls_take;

  // four-phase acceptors, ack drops once req is seen low
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      alu_ack <= 1'b0;
      ls_ack  <= 1'b0;
    end else begin
      if (ls_take) begin
        ls_ack <= 1'b1;
      end else if (!ls_req) begin
        ls_ack <= 1'b0;
      end
      if (alu_take) begin
        alu_ack <= 1'b1;
      end else if (!alu_req) begin
        alu_ack <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      iss_valid <= 1'b0;
    end else if (ls_take || alu_take) begin
      iss_valid <= 1'b1;
    end else if (!ex_hold) begin
      iss_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ls_take) begin
      iss_is_ls    <= 1'b1;
      iss_op       <= ls_op;
      // store: val_a is the base, val_b the data with no offset
      iss_val_a    <= ls_val_a;
      iss_val_b    <= ls_val_b;
      iss_rob_idx  <= ls_rob_idx;
      iss_set_nzcv <= 1'b0;
      iss_nzcv     <= '0;
      iss_cond     <= exec_pkg::AL;
    end else if (alu_take) begin
      iss_is_ls    <= 1'b0;
      iss_op       <= alu_op;
      iss_val_a    <= alu_val_a;
      iss_val_b    <= alu_val_b;
      iss_rob_idx  <= alu_rob_idx;
      iss_set_nzcv <= alu_set_nzcv;
      iss_nzcv     <= alu_nzcv;
      iss_cond     <= alu_cond;
    end
  end

endmodule

`default_nettype wire

/* design/writeback_stage.sv */
`default_nettype none

`include "exec_consts.svh"

module writeback_stage (
  input  wire                         clk,
  input  wire                         arst_n,
  input  wire                         ex_valid,
  input  wire [`ROB_IDX_SIZE-1:0]     ex_rob_idx,
  input  wire [`GPR_SIZE-1:0]         ex_value,
  input  wire                         ex_set_nzcv,
  input  wire exec_pkg::nzcv_t        ex_nzcv,
  input  wire                         rob_ack,
  output logic                        wb_hold,
  output logic                        rob_req,
  output logic [`ROB_IDX_SIZE-1:0]    rob_idx,
  output logic [`GPR_SIZE-1:0]        rob_value,
  output logic                        rob_set_nzcv,
  output exec_pkg::nzcv_t             rob_nzcv
);

  // EMPTY, then REQ until ack, then RELEASE until ack drops
  typedef enum logic [1:0] {
    WB_EMPTY,
    WB_REQ,
    WB_RELEASE
  } wb_state_t;

  wb_state_t state;
  logic      load;

  // slot frees on the edge that sees rob_ack low again
  assign wb_hold = (state == WB_REQ) || ((state == WB_RELEASE) && rob_ack);
  assign load    = ex_valid && !wb_hold;
  assign rob_req = (state == WB_REQ);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= WB_EMPTY;
    end else if (load) begin
      state <= WB_REQ;
    end else begin
      case (state)
        WB_REQ: begin
          if (rob_ack) begin
            state <= WB_RELEASE;
          end
        end
        WB_RELEASE: begin
          if (!rob_ack) begin
            state <= WB_EMPTY;
          end
        end
        default: state <= WB_EMPTY;
      endcase
    end
  end

  // held stable for the whole exchange
  always_ff @(posedge clk) begin
    if (load) begin
      rob_idx      <= ex_rob_idx;
      rob_value    <= ex_value;
      rob_set_nzcv <= ex_set_nzcv;
      rob_nzcv     <= ex_nzcv;
    end
  end

endmodule

`default_nettype wire

/* exec_unit.f */
+incdir+common
common/exec_pkg.sv
design/alu.sv
lsu/lsu_addr.sv
lsu/data_mem.sv
design/issue_stage.sv
design/execute_stage.sv
design/writeback_stage.sv
design/exec_unit.sv
verif/exec_unit_props.sv
verif/exec_unit_tb.sv

/* lsu/data_mem.sv */
`default_nettype none

`include "exec_consts.svh"

module data_mem (
  input  wire                                 clk,
  input  wire                                 en,
  input  wire                                 wr_en,
  input  wire [$clog2(`DMEM_WORDS)-1:0]       word_idx,
  input  wire [`GPR_SIZE-1:0]                 wdata,
  output logic [`GPR_SIZE-1:0]                rdata
);

  logic [`GPR_SIZE-1:0] mem [`DMEM_WORDS];

  // rdata only changes on an enabled edge
  always_ff @(posedge clk) begin
    if (en) begin
      if (wr_en) begin
        mem[word_idx] <= wdata;
        // write-through, the store reports its own data
        rdata <= wdata;
      end else begin
        rdata <= mem[word_idx];
      end
    end
  end

endmodule

`default_nettype wire

/* lsu/lsu_addr.sv */
`default_nettype none

`include "exec_consts.svh"

module lsu_addr (
  input  wire exec_pkg::fu_op_t               op,
  input  wire [`GPR_SIZE-1:0]                 val_a,
  input  wire [`GPR_SIZE-1:0]                 val_b,
  output logic [$clog2(`DMEM_WORDS)-1:0]      word_idx,
  output logic                                wr_en
);

  localparam int IDX_W = $clog2(`DMEM_WORDS);

  logic [`GPR_SIZE-1:0] addr;

  assign wr_en = (op == exec_pkg::STUR);

  // stores use the base alone, val_b carries their data
  assign addr = wr_en ? val_a : val_a + val_b;

  // doubleword aligned, wraps at the memory depth
  assign word_idx = addr[3 +: IDX_W];

endmodule

`default_nettype wire

/* verif/exec_unit_props.sv */
`default_nettype none

`include "exec_consts.svh"

module exec_unit_props (
  input  wire                         clk,
  input  wire                         arst_n,
  input  wire                         alu_req,
  input  wire                         alu_ack,
  input  wire                         ls_req,
  input  wire                         ls_ack,
  input  wire                         rob_req,
  input  wire                         rob_ack,
  input  wire [`ROB_IDX_SIZE-1:0]     rob_idx,
  input  wire [`GPR_SIZE-1:0]         rob_value,
  input  wire                         rob_set_nzcv,
  input  wire exec_pkg::nzcv_t        rob_nzcv,
  input  wire                         iss_valid,
  input  wire                         ex_valid
);

  // ack answers a req that was up at the capture edge
  alu_ack_after_req: assert property (
    @(posedge clk) disable iff (!arst_n) $rose(alu_ack) |-> $past(alu_req)
  ) else $error("alu_ack rose without alu_req");

  ls_ack_after_req: assert property (
    @(posedge clk) disable iff (!arst_n) $rose(ls_ack) |-> $past(ls_req)
  ) else $error("ls_ack rose without ls_req");

  // only one station is taken per edge
  acks_exclusive: assert property (
    @(posedge clk) disable iff (!arst_n) !($rose(alu_ack) && $rose(ls_ack))
  ) else $error("alu_ack and ls_ack rose together");

  rob_data_stable: assert property (
    @(posedge clk) disable iff (!arst_n)
      rob_req && !rob_ack |=> rob_req && $stable(rob_idx) && $stable(rob_value)
        && $stable(rob_set_nzcv) && $stable(rob_nzcv)
  ) else $error("rob_req or its data changed before rob_ack");

  reset_quiet: assert property (
    @(posedge clk) !arst_n |-> !alu_ack && !ls_ack && !rob_req && !iss_valid && !ex_valid
  ) else $error("control outputs not low during reset");

endmodule

`default_nettype wire

/* verif/exec_unit_tb.sv */
`default_nettype none

`include "exec_consts.svh"

module exec_unit_tb;

  localparam int W = `GPR_SIZE;
  localparam int RW = `ROB_IDX_SIZE;
  localparam int TIMEOUT = 40;

  logic                   clk;
  logic                   arst_n;
  logic                   alu_req;
  logic                   alu_ack;
  exec_pkg::fu_op_t       alu_op;
  logic [W-1:0]           alu_val_a;
  logic [W-1:0]           alu_val_b;
  logic [RW-1:0]          alu_rob_idx;
  logic                   alu_set_nzcv;
  exec_pkg::nzcv_t        alu_nzcv;
  exec_pkg::cond_t        alu_cond;
  logic                   ls_req;
  logic                   ls_ack;
  exec_pkg::fu_op_t       ls_op;
  logic [W-1:0]           ls_val_a;
  logic [W-1:0]           ls_val_b;
  logic [RW-1:0]          ls_rob_idx;
  logic                   rob_req;
  logic                   rob_ack;
  logic [RW-1:0]          rob_idx;
  logic [W-1:0]           rob_value;
  logic                   rob_set_nzcv;
  exec_pkg::nzcv_t        rob_nzcv;

  int                     errors;
  int                     checks;
  int                     timeouts;
  logic [RW-1:0]          tag;

  // results in the order the reorder buffer should see them
  logic [RW-1:0]          exp_idx [$];
  logic [W-1:0]           exp_value [$];
  logic                   exp_set [$];
  logic [3:0]             exp_nzcv [$];

  // shadow memory by doubleword index
  logic [W-1:0]           shadow [int];

  exec_unit DUT (.*);

  bind exec_unit exec_unit_props u_props (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    errors++;
    timeouts++;
  endtask

  task automatic check_value(input string name, input logic [W-1:0] got,
                             input logic [W-1:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Fail %s: got %0h, expected %0h", name, got, exp);
      errors++;
    end
  endtask

  function automatic logic [W-1:0] rand_word();
    return {$urandom, $urandom};
  endfunction

  function automatic logic [RW-1:0] new_tag();
    tag = tag + 1'b1;
    return tag;
  endfunction

  function automatic int dword_index(input logic [W-1:0] addr);
    return int'((addr >> 3) % `DMEM_WORDS);
  endfunction

  // f holds {n, z, c, v}
  function automatic logic cond_holds(input logic [3:0] cond, input logic [3:0] f);
    logic base;
    logic res;
    case (cond[3:1])
      3'd0:    base = f[2];
      3'd1:    base = f[1];
      3'd2:    base = f[3];
      3'd3:    base = f[0];
      3'd4:    base = f[1] && !f[2];
      3'd5:    base = (f[3] == f[0]);
      3'd6:    base = (f[3] == f[0]) && !f[2];
      default: base = 1'b1;
    endcase
    // odd codes invert except for the always pair
    res = (cond[0] && cond != 4'hf) ? !base : base;
    return res;
  endfunction

  task automatic model_alu(input exec_pkg::fu_op_t op, input logic [W-1:0] a,
                           input logic [W-1:0] b, input logic set, input logic [3:0] f,
                           input logic [3:0] cond, output logic [W-1:0] value,
                           output logic [3:0] flags);
    logic [W:0] wide;
    logic [W:0] sx;
    logic       take;
    take = cond_holds(cond, f);
    sx = '0;
    case (op)
      exec_pkg::PLUS: begin
        wide = {1'b0, a} + {1'b0, b};
        sx = {a[W-1], a} + {b[W-1], b};
      end
      exec_pkg::MINUS: begin
        // carry means no borrow
        wide = {(a >= b), a - b};
        sx = {a[W-1], a} - {b[W-1], b};
      end
      exec_pkg::ORN:   wide = {1'b0, a | ~b};
      exec_pkg::OR:    wide = {1'b0, a | b};
      exec_pkg::EOR:   wide = {1'b0, a ^ b};
      exec_pkg::AND:   wide = {1'b0, a & b};
      exec_pkg::CSNEG: wide = take ? {1'b0, a} : {(b == '0), -b};
      exec_pkg::CSINC: wide = take ? {1'b0, a} : {(b == '1), b + 1'b1};
      exec_pkg::CSINV: wide = take ? {1'b0, a} : {1'b0, ~b};
      exec_pkg::CSEL:  wide = take ? {1'b0, a} : {1'b0, b};
      exec_pkg::MOV:   wide = {1'b0, a | b};
      default:         wide = '0;
    endcase
    value = wide[W-1:0];
    flags = set ? {value[W-1], value == '0, wide[W], sx[W] ^ sx[W-1]} : f;
  endtask

  task automatic push_expected(input logic [RW-1:0] idx, input logic [W-1:0] value,
                               input logic set, input logic [3:0] flags);
    exp_idx.push_back(idx);
    exp_value.push_back(value);
    exp_set.push_back(set);
    exp_nzcv.push_back(flags);
  endtask

  task automatic expect_alu(input exec_pkg::fu_op_t op, input logic [W-1:0] a,
                            input logic [W-1:0] b, input logic [RW-1:0] idx,
                            input logic set, input logic [3:0] f, input logic [3:0] cond);
    logic [W-1:0] value;
    logic [3:0]   flags;
    model_alu(op, a, b, set, f, cond, value, flags);
    push_expected(idx, value, set, flags);
  endtask

  task automatic expect_mem(input exec_pkg::fu_op_t op, input logic [W-1:0] a,
                            input logic [W-1:0] b, input logic [RW-1:0] idx);
    if (op == exec_pkg::STUR) begin
      shadow[dword_index(a)] = b;
      push_expected(idx, b, 1'b0, 4'h0);
    end else begin
      push_expected(idx, shadow[dword_index(a + b)], 1'b0, 4'h0);
    end
  endtask

  task automatic alu_send(input exec_pkg::fu_op_t op, input logic [W-1:0] a,
                          input logic [W-1:0] b, input logic [RW-1:0] idx,
                          input logic set, input logic [3:0] f, input logic [3:0] cond);
    int n;
    @(negedge clk);
    n = 0;
    while (alu_ack && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (alu_ack) begin
      report_timeout("alu_ack to drop");
    end
    alu_op = op;
    alu_val_a = a;
    alu_val_b = b;
    alu_rob_idx = idx;
    alu_set_nzcv = set;
    alu_nzcv = f;
    alu_cond = exec_pkg::cond_t'(cond);
    alu_req = 1'b1;
    n = 0;
    while (!alu_ack && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!alu_ack) begin
      report_timeout("alu_ack");
    end
    alu_req = 1'b0;
  endtask

  task automatic ls_send(input exec_pkg::fu_op_t op, input logic [W-1:0] a,
                         input logic [W-1:0] b, input logic [RW-1:0] idx);
    int n;
    @(negedge clk);
    n = 0;
    while (ls_ack && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (ls_ack) begin
      report_timeout("ls_ack to drop");
    end
    ls_op = op;
    ls_val_a = a;
    ls_val_b = b;
    ls_rob_idx = idx;
    ls_req = 1'b1;
    n = 0;
    while (!ls_ack && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!ls_ack) begin
      report_timeout("ls_ack");
    end
    ls_req = 1'b0;
  endtask

  // reorder buffer side of the exchange with checks against the queue
  task automatic rob_receive();
    int n;
    @(negedge clk);
    n = 0;
    while (!rob_req && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!rob_req) begin
      report_timeout("rob_req");
      return;
    end
    if (exp_idx.size() == 0) begin
      $display("the DUT delivered a result that was never issued");
      errors++;
    end else begin
      check_value("rob_idx", rob_idx, exp_idx.pop_front());
      check_value("rob_value", rob_value, exp_value.pop_front());
      check_value("rob_set_nzcv", rob_set_nzcv, exp_set.pop_front());
      check_value("rob_nzcv", rob_nzcv, exp_nzcv.pop_front());
    end
    rob_ack = 1'b1;
    n = 0;
    while (rob_req && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (rob_req) begin
      report_timeout("rob_req to drop");
    end
    rob_ack = 1'b0;
  endtask

  task automatic run_alu(input exec_pkg::fu_op_t op, input logic [W-1:0] a,
                         input logic [W-1:0] b, input logic set, input logic [3:0] f,
                         input logic [3:0] cond);
    logic [RW-1:0] idx;
    idx = new_tag();
    expect_alu(op, a, b, idx, set, f, cond);
    alu_send(op, a, b, idx, set, f, cond);
    rob_receive();
  endtask

  task automatic run_mem(input exec_pkg::fu_op_t op, input logic [W-1:0] a,
                         input logic [W-1:0] b);
    logic [RW-1:0] idx;
    idx = new_tag();
    expect_mem(op, a, b, idx);
    ls_send(op, a, b, idx);
    rob_receive();
  endtask

  task automatic single_plus_test();
    logic [W-1:0]  a;
    logic [W-1:0]  b;
    logic [RW-1:0] idx;
    checks++;
    assert (!alu_ack && !ls_ack && !rob_req) else begin
      $display("control outputs are not low after reset");
      errors++;
    end
    a = rand_word();
    b = rand_word();
    idx = new_tag();
    expect_alu(exec_pkg::PLUS, a, b, idx, 1'b1, 4'h0, 4'he);
    alu_send(exec_pkg::PLUS, a, b, idx, 1'b1, 4'h0, 4'he);
    // rob_req is due two edges after the ack
    @(negedge clk);
    check_value("rob_req", rob_req, 1'b0);
    @(negedge clk);
    check_value("rob_req", rob_req, 1'b1);
    rob_receive();
  endtask

  task automatic alu_op_test();
    for (int i = 0; i <= int'(exec_pkg::MOV); i++) begin
      for (int s = 0; s < 2; s++) begin
        run_alu(exec_pkg::fu_op_t'(i), rand_word(), rand_word(), s[0], 4'($urandom),
                4'($urandom));
      end
    end
    // zero, carry, sign and overflow corners
    run_alu(exec_pkg::PLUS, 64'h0, 64'h0, 1'b1, 4'hf, 4'he);
    run_alu(exec_pkg::PLUS, 64'hffff_ffff_ffff_ffff, 64'h1, 1'b1, 4'h0, 4'he);
    run_alu(exec_pkg::PLUS, 64'h7fff_ffff_ffff_ffff, 64'h1, 1'b1, 4'h0, 4'he);
    run_alu(exec_pkg::MINUS, 64'h0, 64'h1, 1'b1, 4'h0, 4'he);
    run_alu(exec_pkg::MINUS, 64'h8000_0000_0000_0000, 64'h1, 1'b1, 4'h0, 4'he);
    run_alu(exec_pkg::MINUS, 64'h5, 64'h5, 1'b1, 4'h0, 4'he);
    run_alu(exec_pkg::AND, 64'hf0f0, 64'h0f0f, 1'b1, 4'hf, 4'he);
  endtask

  task automatic cond_select_test();
    exec_pkg::fu_op_t op;
    for (int c = 0; c < 16; c++) begin
      for (int f = 0; f < 16; f++) begin
        op = exec_pkg::fu_op_t'(int'(exec_pkg::CSNEG) + (c + f) % 4);
        run_alu(op, rand_word(), rand_word(), 1'($urandom), f[3:0], c[3:0]);
      end
    end
  endtask

  task automatic memory_test();
    logic [W-1:0] base;
    logic [W-1:0] other;
    base = rand_word();
    // doubleword aligned base
    base[2:0] = 3'b000;
    other = base + 64'h38;
    run_mem(exec_pkg::STUR, base, rand_word());
    run_mem(exec_pkg::STUR, other, rand_word());
    run_mem(exec_pkg::LDUR, base, 64'h0);
    run_mem(exec_pkg::LDUR, base - 64'h10, 64'h10);
    run_mem(exec_pkg::LDUR, other, 64'h0);
    // low address bits are ignored
    run_mem(exec_pkg::LDUR, base + 64'h5, 64'h0);
    run_mem(exec_pkg::STUR, base, rand_word());
    run_mem(exec_pkg::LDUR, other - 64'h38, 64'h0);
    run_mem(exec_pkg::LDUR, base, 64'h38);
  endtask

  task automatic arbitration_test();
    logic [RW-1:0] ls_idx;
    logic [RW-1:0] alu_idx;
    logic [W-1:0]  addr;
    logic [W-1:0]  data;
    logic [W-1:0]  a;
    logic [W-1:0]  b;
    ls_idx = new_tag();
    alu_idx = new_tag();
    addr = rand_word();
    data = rand_word();
    a = rand_word();
    b = rand_word();
    // load/store wins, so its result comes first
    expect_mem(exec_pkg::STUR, addr, data, ls_idx);
    expect_alu(exec_pkg::EOR, a, b, alu_idx, 1'b1, 4'h3, 4'he);
    fork
      ls_send(exec_pkg::STUR, addr, data, ls_idx);
      alu_send(exec_pkg::EOR, a, b, alu_idx, 1'b1, 4'h3, 4'he);
    join
    rob_receive();
    rob_receive();
  endtask

  task automatic backpressure_test();
    logic [W-1:0]  a [4];
    logic [RW-1:0] idx [4];
    int            n;
    for (int i = 0; i < 4; i++) begin
      a[i] = rand_word();
      idx[i] = new_tag();
      expect_alu(exec_pkg::MINUS, a[i], 64'h3, idx[i], 1'b1, 4'h0, 4'he);
    end
    for (int i = 0; i < 3; i++) begin
      alu_send(exec_pkg::MINUS, a[i], 64'h3, idx[i], 1'b1, 4'h0, 4'he);
    end
    @(negedge clk);
    alu_op = exec_pkg::MINUS;
    alu_val_a = a[3];
    alu_val_b = 64'h3;
    alu_rob_idx = idx[3];
    alu_req = 1'b1;
    repeat (8) begin
      @(negedge clk);
      checks++;
      assert (!alu_ack) else begin
        $display("a fourth request was taken while the pipeline was full");
        errors++;
      end
    end
    fork
      begin
        n = 0;
        while (!alu_ack && n < TIMEOUT) begin
          @(negedge clk);
          n++;
        end
        if (!alu_ack) begin
          report_timeout("alu_ack on the fourth request");
        end
        alu_req = 1'b0;
      end
      begin
        repeat (4) rob_receive();
      end
    join
    // nothing repeated once the pipeline is drained
    repeat (4) @(negedge clk);
    check_value("rob_req", rob_req, 1'b0);
  endtask

  initial begin
    errors = 0;
    checks = 0;
    timeouts = 0;
    tag = '0;
    alu_req = 1'b0;
    alu_op = exec_pkg::PLUS;
    alu_val_a = '0;
    alu_val_b = '0;
    alu_rob_idx = '0;
    alu_set_nzcv = 1'b0;
    alu_nzcv = '0;
    alu_cond = exec_pkg::AL;
    ls_req = 1'b0;
    ls_op = exec_pkg::LDUR;
    ls_val_a = '0;
    ls_val_b = '0;
    ls_rob_idx = '0;
    rob_ack = 1'b0;
    arst_n = 1'b1;
    void'($urandom(32'h8c2));
    #1 arst_n = 1'b0;
    repeat (5) @(negedge clk);
    arst_n = 1'b1;

    single_plus_test();
    alu_op_test();
    cond_select_test();
    memory_test();
    arbitration_test();
    backpressure_test();

    if (exp_idx.size() != 0) begin
      $display("%0d issued results never reached the reorder buffer", exp_idx.size());
      errors++;
    end
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
